/* bench/mem_trace.txt */
# name op i_addr d_addr wdata wmask exp_inst exp_rdata, values in hex
# op: I fetch, R read, W write, B fetch with read, D fetch with write
wr_full_0010     W 00000000 00000010 deadbeef ffffffff 00000000 00000000
rd_full_0010     R 00000000 00000010 00000000 00000000 00000000 deadbeef
wr_low_half      W 00000000 00000010 12345678 0000ffff 00000000 00000000
rd_low_half      R 00000000 00000010 00000000 00000000 00000000 dead5678
wr_mid_bytes     W 00000000 00000010 a5a5a5a5 ff00ff00 00000000 00000000
rd_mid_bytes     R 00000000 00000010 00000000 00000000 00000000 a5ada578
wr_nibbles       W 00000000 00000010 ffffffff 0f0f0f0f 00000000 00000000
rd_nibbles       R 00000000 00000010 00000000 00000000 00000000 afafaf7f
wr_no_mask       W 00000000 00000010 00000000 00000000 00000000 00000000
rd_no_mask       R 00000000 00000010 00000000 00000000 00000000 afafaf7f
wr_word_0100     W 00000000 00000100 13579bdf ffffffff 00000000 00000000
fetch_0100       I 00000100 00000000 00000000 00000000 13579bdf 00000000
fetch_wrap_4100  I 00004100 00000000 00000000 00000000 13579bdf 00000000
fetch_wrap_high  I ffffc100 00000000 00000000 00000000 13579bdf 00000000
fetch_0010       I 00000010 00000000 00000000 00000000 afafaf7f 00000000
wr_wrap_0200     W 00000000 80000200 0badf00d ffffffff 00000000 00000000
rd_0200          R 00000000 00000200 00000000 00000000 00000000 0badf00d
pair_rd          B 00000100 00000010 00000000 00000000 13579bdf afafaf7f
pair_rd_same     B 00000200 00000200 00000000 00000000 0badf00d 0badf00d
pair_wr          D 00000010 00000100 0f1e2d3c ffffffff afafaf7f 00000000
rd_after_pair    R 00000000 00000100 00000000 00000000 00000000 0f1e2d3c
pair_wr_same     D 00000200 00000200 cafe0000 ffff0000 0badf00d 00000000
rd_same_after    R 00000000 00000200 00000000 00000000 00000000 cafef00d
fetch_same_after I 00000200 00000000 00000000 00000000 cafef00d 00000000
wr_back2back     W 00000000 00000300 11223344 ffffffff 00000000 00000000
rd_back2back     R 00000000 00000300 00000000 00000000 00000000 11223344
wr_b2b_part      W 00000000 00000300 aabbccdd ffff0000 00000000 00000000
rd_b2b_part      R 00000000 00000300 00000000 00000000 00000000 aabb3344
wr_last_word     W 00000000 00003ffc 55aa55aa ffffffff 00000000 00000000
rd_last_wrapped  R 00000000 00007ffc 00000000 00000000 00000000 55aa55aa

/* mem_subsystem.f */
+incdir+source
source/mem_if_pkg.sv
source/unified_memory.sv
source/mem_port_arbiter.sv
source/mem_subsystem.sv
bench/mem_subsystem_props.sv
bench/mem_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the memory front end testbench with Verilator
# the trace file path is relative to the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mem_subsystem.f \
	--top-module mem_subsystem_tb \
	&& ./obj_dir/Vmem_subsystem_tb +verilator+error+limit+100 \
		| tee /dev/stderr | grep -q "TESTS PASSED" \
	&& echo "run_sim: simulation passed" \
	|| { echo "run_sim: simulation failed"; exit 1; }

/* bench/mem_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb
	import mem_if_pkg::*;
();

	logic        clk;
	logic        rst_n;
	logic        inst_start;
	logic        inst_ready;
	logic [31:0] i_addr;
	logic [31:0] inst;
	logic        inst_valid;
	mem_cmd_e    d_cmd;
	logic        d_cmd_ready;
	data_req_t   d_req;
	logic [31:0] rdata;
	logic        rdata_valid;

	// trace columns with one entry per test
	string       t_name[$];
	string       t_op[$];
	logic [31:0] t_iaddr[$];
	logic [31:0] t_daddr[$];
	logic [31:0] t_wdata[$];
	logic [31:0] t_wmask[$];
	logic [31:0] t_einst[$];
	logic [31:0] t_erdata[$];

	// run length guard set once the trace is known
	int cycle_count   = 0;
	int timeout_limit = 0;

	mem_subsystem u_mem_subsystem (
		.clk         (clk),
		.rst_n       (rst_n),
		.inst_start  (inst_start),
		.inst_ready  (inst_ready),
		.i_addr      (i_addr),
		.inst        (inst),
		.inst_valid  (inst_valid),
		.d_cmd       (d_cmd),
		.d_cmd_ready (d_cmd_ready),
		.d_req       (d_req),
		.rdata       (rdata),
		.rdata_valid (rdata_valid)
	);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("Error: %s", why);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_inst(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (act !== exp) begin
			$display("Mismatch in %s: inst expected %h, actual %h", name, exp, act);
			abort_run("wrong fetched word");
		end
	endtask

	task automatic check_rdata(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (act !== exp) begin
			$display("Mismatch in %s: rdata expected %h, actual %h", name, exp, act);
			abort_run("wrong read data");
		end
	endtask

	// fills the trace queues and skips comments and blank lines
	task automatic load_trace();
		int          fd;
		int          code;
		int          n;
		string       line;
		string       name;
		string       op;
		logic [31:0] v[6];
		fd = $fopen("bench/mem_trace.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open bench/mem_trace.txt");
		end
		code = $fgets(line, fd);
		while (code != 0) begin
			if (line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%s %s %h %h %h %h %h %h", name, op,
					v[0], v[1], v[2], v[3], v[4], v[5]);
				if (n != 8) begin
					abort_run("malformed line in the trace file");
				end
				t_name.push_back(name);
				t_op.push_back(op);
				t_iaddr.push_back(v[0]);
				t_daddr.push_back(v[1]);
				t_wdata.push_back(v[2]);
				t_wmask.push_back(v[3]);
				t_einst.push_back(v[4]);
				t_erdata.push_back(v[5]);
			end
			code = $fgets(line, fd);
		end
		$fclose(fd);
	endtask

	// presents one trace line and collects results until ready returns
	task automatic run_test(input int idx);
		string name;
		string op;
		bit    need_inst;
		bit    need_rd;
		bit    got_inst;
		bit    got_rd;
		bit    done;
		name      = t_name[idx];
		op        = t_op[idx];
		need_inst = (op == "I") || (op == "B") || (op == "D");
		need_rd   = (op == "R") || (op == "B");
		if (!(op == "I" || op == "R" || op == "W" || op == "B" || op == "D")) begin
			abort_run({"unknown operation letter in test ", name});
		end
		// wait for open ports sampled away from the edge
		while (!inst_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		inst_start <= need_inst;
		i_addr     <= t_iaddr[idx];
		if (op == "R" || op == "B") begin
			d_cmd <= cmd_read;
		end else if (op == "W" || op == "D") begin
			d_cmd <= cmd_write;
		end
		d_req <= '{addr: t_daddr[idx], wdata: t_wdata[idx], wmask: t_wmask[idx]};
		// inputs drop right after the accepting edge
		@(posedge clk);
		inst_start <= 1'b0;
		d_cmd      <= cmd_nop;
		@(negedge clk);
		if (inst_ready || d_cmd_ready) begin
			abort_run({"request not accepted in test ", name});
		end
		got_inst = 1'b0;
		got_rd   = 1'b0;
		done     = 1'b0;
		while (!done) begin
			if (inst_valid) begin
				if (!need_inst || got_inst) begin
					abort_run({"unexpected inst_valid in test ", name});
				end
				got_inst = 1'b1;
				check_inst(name, t_einst[idx], inst);
			end
			if (rdata_valid) begin
				if (!need_rd || got_rd) begin
					abort_run({"unexpected rdata_valid in test ", name});
				end
				// fetch half of a pair must come first
				if (need_inst && !got_inst) begin
					abort_run({"rdata_valid came before inst_valid in test ", name});
				end
				got_rd = 1'b1;
				check_rdata(name, t_erdata[idx], rdata);
			end
			if (inst_ready) begin
				if ((need_inst && !got_inst) || (need_rd && !got_rd)) begin
					abort_run({"ready rose before all results arrived in test ", name});
				end
				done = 1'b1;
			end else begin
				@(negedge clk);
			end
		end
	endtask

	// run guard and assertion watch
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
			abort_run("timeout, the DUT stopped responding");
		end
		if (u_mem_subsystem.u_props.fail_total != 0) begin
			abort_run("a handshake assertion failed");
		end
	end

	initial begin
		rst_n      = 1'b0;
		inst_start = 1'b0;
		i_addr     = '0;
		d_cmd      = cmd_nop;
		d_req      = '0;
		load_trace();
		// 20 cycles per test plus reset
		timeout_limit = t_name.size() * 20 + 8;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		if (!inst_ready || !d_cmd_ready) begin
			abort_run("ready is low after reset");
		end
		for (int i = 0; i < t_name.size(); i++) begin
			run_test(i);
		end
		// let a late assertion show up
		repeat (3) @(posedge clk);
		if (u_mem_subsystem.u_props.fail_total == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			abort_run("a handshake assertion failed");
		end
	end

endmodule

`default_nettype wire

/* bench/mem_subsystem_props.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_props (
	input logic clk,
	input logic rst_n,
	input logic inst_ready,
	input logic d_cmd_ready,
	input logic inst_valid,
	input logic rdata_valid
);

	// failed assertions so far, polled by the testbench
	int unsigned fail_total = 0;

	// both ports open and close together
	a_ready_pair: assert property (@(posedge clk) disable iff (!rst_n)
		inst_ready == d_cmd_ready)
		else begin
			fail_total = fail_total + 1;
			$error("inst_ready and d_cmd_ready differ");
		end

	// fetch result is a single-cycle pulse
	a_inst_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		inst_valid |=> !inst_valid)
		else begin
			fail_total = fail_total + 1;
			$error("inst_valid held for more than one cycle");
		end

	// data result is a single-cycle pulse
	a_rdata_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		rdata_valid |=> !rdata_valid)
		else begin
			fail_total = fail_total + 1;
			$error("rdata_valid held for more than one cycle");
		end

	// one memory port, so never two results at once
	a_valid_apart: assert property (@(posedge clk) disable iff (!rst_n)
		!(inst_valid && rdata_valid))
		else begin
			fail_total = fail_total + 1;
			$error("inst_valid and rdata_valid high together");
		end

	// results only come back while the ports are closed
	a_valid_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(inst_valid || rdata_valid) |-> !inst_ready)
		else begin
			fail_total = fail_total + 1;
			$error("valid pulse while ready is high");
		end

	// ports open right after reset
	a_ready_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> (inst_ready && d_cmd_ready))
		else begin
			fail_total = fail_total + 1;
			$error("ready low after reset");
		end

endmodule

// attach to every instance of the top level
bind mem_subsystem mem_subsystem_props u_props (
	.clk         (clk),
	.rst_n       (rst_n),
	.inst_ready  (inst_ready),
	.d_cmd_ready (d_cmd_ready),
	.inst_valid  (inst_valid),
	.rdata_valid (rdata_valid)
);

`default_nettype wire

/* source/mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem
	import mem_if_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,

	// instruction fetch port
	input  logic        inst_start,
	output logic        inst_ready,
	input  logic [31:0] i_addr,
	output logic [31:0] inst,
	output logic        inst_valid,

	// data port
	input  mem_cmd_e    d_cmd,
	output logic        d_cmd_ready,
	input  data_req_t   d_req,
	output logic [31:0] rdata,
	output logic        rdata_valid
);

	// arbiter to memory
	logic        cmd_start;
	mem_req_t    mem_req;
	// memory back to arbiter
	logic        cmd_ready;
	logic [31:0] mem_rdata;
	logic        mem_rdata_valid;

	// serializes fetch and data onto one memory port
	mem_port_arbiter u_arbiter (
		.clk             (clk),
		.rst_n           (rst_n),
		.inst_start      (inst_start),
		.inst_ready      (inst_ready),
		.i_addr          (i_addr),
		.inst            (inst),
		.inst_valid      (inst_valid),
		.d_cmd           (d_cmd),
		.d_cmd_ready     (d_cmd_ready),
		.d_req           (d_req),
		.rdata           (rdata),
		.rdata_valid     (rdata_valid),
		.cmd_start       (cmd_start),
		.mem_req         (mem_req),
		.cmd_ready       (cmd_ready),
		.mem_rdata       (mem_rdata),
		.mem_rdata_valid (mem_rdata_valid)
	);

	// single-ported word store
	unified_memory u_memory (
		.clk         (clk),
		.rst_n       (rst_n),
		.cmd_start   (cmd_start),
		.mem_req     (mem_req),
		.cmd_ready   (cmd_ready),
		.rdata       (mem_rdata),
		.rdata_valid (mem_rdata_valid)
	);

endmodule

`default_nettype wire

/* source/mem_port_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_port_arbiter
	import mem_if_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,

	// instruction port
	input  logic        inst_start,
	output logic        inst_ready,
	input  logic [31:0] i_addr,
	output logic [31:0] inst,
	output logic        inst_valid,

	// data port
	input  mem_cmd_e    d_cmd,
	output logic        d_cmd_ready,
	input  data_req_t   d_req,
	output logic [31:0] rdata,
	output logic        rdata_valid,

	// memory side
	output logic        cmd_start,
	output mem_req_t    mem_req,
	input  logic        cmd_ready,
	input  logic [31:0] mem_rdata,
	input  logic        mem_rdata_valid
);

	typedef enum logic [1:0] {
		// idle, both ports open
		st_wait_cmd       = 2'd0,
		// request held, memory still busy
		st_wait_mem_ready = 2'd1,
		// read issued, waiting for the data pulse
		st_wait_read      = 2'd2,
		// one operation finished
		st_end            = 2'd3
	} arb_state_e;

	arb_state_e state;

	// current operation is the fetch
	logic      cmd_is_inst;
	// saved data command, nop when only a fetch came in
	mem_cmd_e  save_cmd;
	// saved payloads
	logic [31:0] save_i_addr;
	data_req_t   save_req;

	// ports open only while idle
	logic ports_open;
	// data port asks for work
	logic d_cmd_is_op;
	// request set taken on this edge
	logic accept;
	// next operation needs the read wait
	logic issue_read;

	assign ports_open  = (state == st_wait_cmd);
	assign inst_ready  = ports_open;
	assign d_cmd_ready = ports_open;

	assign d_cmd_is_op = (d_cmd != cmd_nop);
	assign accept      = ports_open && (inst_start || d_cmd_is_op);
	// fetch is always a read
	assign issue_read  = cmd_is_inst || (save_cmd == cmd_read);

	// control path
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= st_wait_cmd;
			cmd_is_inst <= 1'b0;
			save_cmd    <= cmd_nop;
			cmd_start   <= 1'b0;
			inst_valid  <= 1'b0;
			rdata_valid <= 1'b0;
		end else begin
			// pulses drop unless set below
			cmd_start   <= 1'b0;
			inst_valid  <= 1'b0;
			rdata_valid <= 1'b0;
			case (state)
				st_wait_cmd: begin
					if (accept) begin
						// fetch goes first when both arrive
						cmd_is_inst <= inst_start;
						save_cmd    <= d_cmd;
						state       <= st_wait_mem_ready;
					end
				end
				st_wait_mem_ready: begin
					// start only while the memory is ready
					if (cmd_ready) begin
						cmd_start <= 1'b1;
						if (issue_read) begin
							state <= st_wait_read;
						end else begin
							// writes get no response
							state <= st_end;
						end
					end
				end
				st_wait_read: begin
					if (mem_rdata_valid) begin
						// route by the current operation
						if (cmd_is_inst) begin
							inst_valid <= 1'b1;
						end else begin
							rdata_valid <= 1'b1;
						end
						state <= st_end;
					end
				end
				st_end: begin
					// data half of a pair still to do
					if (cmd_is_inst && save_cmd != cmd_nop) begin
						cmd_is_inst <= 1'b0;
						state       <= st_wait_mem_ready;
					end else begin
						state <= st_wait_cmd;
					end
				end
				default: begin
					state <= st_wait_cmd;
				end
			endcase
		end
	end

	// payload path
	always_ff @(posedge clk) begin
		if (accept) begin
			save_i_addr <= i_addr;
			save_req    <= d_req;
		end
		if (state == st_wait_mem_ready && cmd_ready) begin
			if (cmd_is_inst) begin
				// fetch carries no write data
				mem_req <= '{write: 1'b0, addr: save_i_addr, wdata: '0, wmask: '0};
			end else begin
				mem_req <= '{
					write: (save_cmd == cmd_write),
					addr:  save_req.addr,
					wdata: save_req.wdata,
					wmask: save_req.wmask
				};
			end
		end
		// result words held after the pulse
		if (state == st_wait_read && mem_rdata_valid) begin
			if (cmd_is_inst) begin
				inst <= mem_rdata;
			end else begin
				rdata <= mem_rdata;
			end
		end
	end

endmodule

`default_nettype wire

/* source/unified_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_if_macros.svh"

module unified_memory
	import mem_if_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        cmd_start,
	input  mem_req_t    mem_req,
	output logic        cmd_ready,
	output logic [31:0] rdata,
	output logic        rdata_valid
);

	// width of the word index
	localparam int unsigned IDX_W = `MEM_IDX_MSB - `MEM_IDX_LSB + 1;
	// countdown must hold the full latency
	localparam int unsigned CNT_W = $clog2(`MEM_RD_LATENCY + 1);

	// word storage
	logic [31:0] mem [0:`MEM_WORDS-1];

	// word index of the incoming request
	logic [IDX_W-1:0] req_idx;
	// index held for the pending read
	logic [IDX_W-1:0] rd_idx;
	// read countdown, zero when no read runs
	logic [CNT_W-1:0] rd_cnt;
	// command taken on this edge
	logic             accept;

	assign req_idx = mem_req.addr[`MEM_IDX_MSB:`MEM_IDX_LSB];
	assign accept  = cmd_start && cmd_ready;

	// handshake and countdown
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cmd_ready   <= 1'b1;
			rd_cnt      <= '0;
			rdata_valid <= 1'b0;
		end else begin
			// valid is a single-cycle pulse
			rdata_valid <= 1'b0;
			if (accept) begin
				// busy from the accepting edge on
				cmd_ready <= 1'b0;
				if (!mem_req.write) begin
					rd_cnt <= CNT_W'(`MEM_RD_LATENCY);
				end
			end else if (rd_cnt != '0) begin
				rd_cnt <= rd_cnt - CNT_W'(1);
				// last step of the countdown
				if (rd_cnt == CNT_W'(1)) begin
					rdata_valid <= 1'b1;
				end
			end else if (!cmd_ready) begin
				// write done, or read pulse just ended
				cmd_ready <= 1'b1;
			end
		end
	end

	// array and read data
	always_ff @(posedge clk) begin
		if (accept) begin
			if (mem_req.write) begin
				// keep unmasked bits, take masked ones
				mem[req_idx] <= (mem[req_idx] & ~mem_req.wmask) |
					(mem_req.wdata & mem_req.wmask);
			end else begin
				rd_idx <= req_idx;
			end
		end
		// word shows up together with the valid pulse
		if (rd_cnt == CNT_W'(1)) begin
			rdata <= mem[rd_idx];
		end
	end

endmodule

`default_nettype wire

/* source/mem_if_pkg.sv */
`default_nettype none

package mem_if_pkg;

	// data-port command
	// nop leaves the port idle, the others start a request set
	typedef enum logic [1:0] {
		cmd_nop   = 2'd0,
		cmd_read  = 2'd1,
		cmd_write = 2'd2
	} mem_cmd_e;

	// data-port request payload
	// sampled together with d_cmd on the accepting edge
	typedef struct packed {
		// byte address, word index taken from the low bits
		logic [31:0] addr;
		// write data, ignored for reads
		logic [31:0] wdata;
		// bitwise write mask, 1 means replace this bit
		logic [31:0] wmask;
	} data_req_t;

	// request from the arbiter to the word memory
	// one command per cmd_start pulse
	typedef struct packed {
		// 1 for a masked write, 0 for a read
		logic        write;
		// byte address of the word
		logic [31:0] addr;
		// write data
		logic [31:0] wdata;
		// write mask, bit for bit
		logic [31:0] wmask;
	} mem_req_t;

	// 96 bits for the port payload, 97 with the write flag

endpackage

`default_nettype wire

/* source/mem_if_macros.svh */
`ifndef MEM_IF_MACROS_SVH
`define MEM_IF_MACROS_SVH

// memory depth in 32-bit words
`define MEM_WORDS 4096

// word index slice of the byte address
// bits above the msb are dropped so addresses wrap
`define MEM_IDX_MSB 13
`define MEM_IDX_LSB 2

// cycles from the accepted read to rdata_valid
// must be at least 1
`define MEM_RD_LATENCY 2

// 12 index bits cover the 4096 words
// keep MEM_WORDS and the slice in step

`endif
